// ==== sys_pkg.sv ====
// Shared types, host command codes and video timing defaults
// Timing defaults describe 1280x720 at 60 Hz

package sys_pkg;

	// ========================================
	// Widths with a meaning
	// ========================================

	typedef logic [15:0] word_t;
	typedef logic [7:0]  cmd_t;
	typedef logic [11:0] timing_t;
	typedef logic [15:0] sample_t;

	// Bit 4 mutes, bits 3:0 give the right shift
	typedef logic [4:0]  vol_t;

	typedef logic [7:0]  led_mask_t;

	// Host frame decoder
	typedef enum logic {
		st_cmd,
		st_data
	} host_state_t;

	// ========================================
	// Host commands
	// ========================================

	localparam cmd_t CMD_TIMING = 8'h20;
	localparam cmd_t CMD_LED    = 8'h25;
	localparam cmd_t CMD_VOLUME = 8'h26;

	// Data words that land in timing registers, the rest are dropped
	localparam int TIMING_WORDS = 8;

	// ========================================
	// Video timing defaults
	// ========================================

	localparam timing_t WIDTH_DEF  = 12'd1280;
	localparam timing_t HFP_DEF    = 12'd110;
	localparam timing_t HS_DEF     = 12'd40;
	localparam timing_t HBP_DEF    = 12'd220;
	localparam timing_t HEIGHT_DEF = 12'd720;
	localparam timing_t VFP_DEF    = 12'd5;
	localparam timing_t VS_DEF     = 12'd5;
	localparam timing_t VBP_DEF    = 12'd20;

	// Phase length counter in the sync normalizer
	localparam int SYNC_CNT_W = 16;

endpackage

// ==== host_cmd.sv ====
// Host must hold io_din stable while io_clk is high
// Register writes land 3 cycles after io_clk rises, together with io_ack

`timescale 1ns/10ps

module host_cmd (
	input  logic               FPGA_CLK2_50,
	input  logic               resetd,
	input  sys_pkg::word_t     io_din,
	input  logic               io_clk,
	input  logic               io_uio,
	output logic               io_ack,
	output sys_pkg::timing_t   width,
	output sys_pkg::timing_t   hfp,
	output sys_pkg::timing_t   hs_len,
	output sys_pkg::timing_t   hbp,
	output sys_pkg::timing_t   height,
	output sys_pkg::timing_t   vfp,
	output sys_pkg::timing_t   vs_len,
	output sys_pkg::timing_t   vbp,
	output sys_pkg::led_mask_t led_overtake,
	output sys_pkg::led_mask_t led_state,
	output sys_pkg::vol_t      vol_att
);
	import sys_pkg::*;

	logic        clk_d1;
	logic        clk_d2;
	logic        uio_d1;
	logic        uio_d2;
	word_t       din_d1;
	word_t       din_d2;
	logic        strobe;
	host_state_t state;
	cmd_t        cmd;
	logic [3:0]  cnt;

	// ========================================
	// Strobe synchronizer and acknowledge
	// ========================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			clk_d1 <= 1'b0;
			clk_d2 <= 1'b0;
			uio_d1 <= 1'b0;
			uio_d2 <= 1'b0;
			io_ack <= 1'b0;
		end else begin
			clk_d1 <= io_clk;
			clk_d2 <= clk_d1;
			uio_d1 <= io_uio;
			uio_d2 <= uio_d1;
			// Third stage doubles as the edge reference
			io_ack <= clk_d2;
		end
	end

	always_ff @(posedge FPGA_CLK2_50) begin
		din_d1 <= io_din;
		din_d2 <= din_d1;
	end

	assign strobe = clk_d2 & ~io_ack;

	// ========================================
	// Frame decoder
	// ========================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			state        <= st_cmd;
			cmd          <= '0;
			cnt          <= '0;
			width        <= WIDTH_DEF;
			hfp          <= HFP_DEF;
			hs_len       <= HS_DEF;
			hbp          <= HBP_DEF;
			height       <= HEIGHT_DEF;
			vfp          <= VFP_DEF;
			vs_len       <= VS_DEF;
			vbp          <= VBP_DEF;
			led_overtake <= '0;
			led_state    <= '0;
			vol_att      <= '0;
		end else if (!uio_d2) begin
			// Frame closed, next word is a command again
			state <= st_cmd;
		end else if (strobe) begin
			case (state)
				st_cmd: begin
					cmd   <= din_d2[7:0];
					cnt   <= '0;
					state <= st_data;
				end
				st_data: begin
					case (cmd)
						CMD_TIMING: begin
							// Words past the eighth carry PLL data, not used here
							if (cnt < TIMING_WORDS) begin
								cnt <= cnt + 4'd1;
								case (cnt[2:0])
									3'd0: width  <= din_d2[11:0];
									3'd1: hfp    <= din_d2[11:0];
									3'd2: hs_len <= din_d2[11:0];
									3'd3: hbp    <= din_d2[11:0];
									3'd4: height <= din_d2[11:0];
									3'd5: vfp    <= din_d2[11:0];
									3'd6: vs_len <= din_d2[11:0];
									default: vbp <= din_d2[11:0];
								endcase
							end
						end
						CMD_LED: begin
							led_overtake <= din_d2[15:8];
							led_state    <= din_d2[7:0];
						end
						CMD_VOLUME: begin
							vol_att <= din_d2[4:0];
						end
						default: begin
							// Unknown command, data dropped
						end
					endcase
				end
				default: begin
					state <= st_cmd;
				end
			endcase
		end
	end

endmodule

// ==== audio_mix.sv ====
// Two-cycle pipeline, one sample pair per cycle
// audio_s picks signed or unsigned samples; sums wrap at 16 bits

`timescale 1ns/10ps

module audio_mix (
	input  logic             FPGA_CLK2_50,
	input  logic             resetd,
	input  sys_pkg::sample_t audio_ls,
	input  sys_pkg::sample_t audio_rs,
	input  logic             audio_s,
	input  logic [1:0]       audio_mix,
	input  sys_pkg::vol_t    vol_att,
	output sys_pkg::sample_t audio_l,
	output sys_pkg::sample_t audio_r
);
	import sys_pkg::*;

	sample_t al;
	sample_t ar;
	logic    s_d1;

	// Right shift, arithmetic for signed samples
	function automatic sample_t shr(input sample_t x, input logic [3:0] n, input logic s);
		if (s) begin
			shr = $signed(x) >>> n;
		end else begin
			shr = x >> n;
		end
	endfunction

	// One output channel from its own and the opposite sample
	function automatic sample_t mix_ch(input sample_t own, input sample_t other,
			input logic [1:0] mix, input logic s);
		case (mix)
			2'd0: mix_ch = own;
			2'd1: mix_ch = own - shr(own, 4'd3, s) + shr(other, 4'd3, s);
			2'd2: mix_ch = own - shr(own, 4'd2, s) + shr(other, 4'd2, s);
			default: mix_ch = shr(own, 4'd1, s) + shr(other, 4'd1, s);
		endcase
	endfunction

	// ========================================
	// Stage 1, cross mix
	// ========================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			al   <= '0;
			ar   <= '0;
			s_d1 <= 1'b0;
		end else begin
			al   <= mix_ch(audio_ls, audio_rs, audio_mix, audio_s);
			ar   <= mix_ch(audio_rs, audio_ls, audio_mix, audio_s);
			s_d1 <= audio_s;
		end
	end

	// ========================================
	// Stage 2, attenuation
	// ========================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			audio_l <= '0;
			audio_r <= '0;
		end else if (vol_att[4]) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			// Signedness follows the sample now in stage 1
			audio_l <= shr(al, vol_att[3:0], s_d1);
			audio_r <= shr(ar, vol_att[3:0], s_d1);
		end
	end

endmodule

// ==== panel_leds.sv ====
// Board LED outputs are active high and registered one cycle after the inputs

`timescale 1ns/10ps

module panel_leds (
	input  logic               FPGA_CLK2_50,
	input  logic               resetd,
	input  logic               led_user,
	input  logic [1:0]         led_power,
	input  logic [1:0]         led_disk,
	input  sys_pkg::led_mask_t led_overtake,
	input  sys_pkg::led_mask_t led_state,
	output logic               led_p,
	output logic               led_d,
	output logic               led_u,
	output sys_pkg::led_mask_t led
);
	import sys_pkg::*;

	logic      p_c;
	logic      d_c;
	logic      u_c;
	led_mask_t dflt;

	assign p_c = led_power[1] ? ~led_power[0] : 1'b0;
	// Only bit 0 drives the disk LED
	assign d_c = ~led_disk[0];
	assign u_c = ~led_user;

	// Main bank pattern when the host does not override
	assign dflt = {3'b000, ~p_c, 1'b0, ~d_c, 1'b0, ~u_c};

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			led_p <= 1'b0;
			led_d <= 1'b0;
			led_u <= 1'b0;
			led   <= '0;
		end else begin
			led_p <= p_c;
			led_d <= d_c;
			led_u <= u_c;
			led   <= (led_overtake & led_state) | (~led_overtake & dflt);
		end
	end

endmodule

// ==== sync_fix.sv ====
// Output is high during the shorter sync phase, no added latency
// Polarity settles after two full periods; counter saturates on a stuck input

`timescale 1ns/10ps

module sync_fix (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic sync_in,
	output logic sync_out
);
	import sys_pkg::*;

	logic                  s1;
	logic                  s2;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] len_hi;
	logic [SYNC_CNT_W-1:0] len_lo;
	logic                  pol;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			len_hi <= '0;
			len_lo <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;

			// Rising edge closes a low phase
			if (s1 & ~s2) begin
				len_lo <= cnt;
			end
			// Falling edge closes a high phase
			if (~s1 & s2) begin
				len_hi <= cnt;
			end

			if (s1 != s2) begin
				cnt <= '0;
			end else if (~&cnt) begin
				cnt <= cnt + 1'b1;
			end

			pol <= len_hi > len_lo;
		end
	end

	assign sync_out = sync_in ^ pol;

endmodule

// ==== sys_core.sv ====
// Always-on board core on a single 50 MHz clock
// Audio, LED and sync inputs come from the emulator side

`timescale 1ns/10ps

module sys_core (
	input  logic               FPGA_CLK2_50,
	input  logic               resetd,

	// Host command port
	input  sys_pkg::word_t     io_din,
	input  logic               io_clk,
	input  logic               io_uio,
	output logic               io_ack,

	// Audio
	input  sys_pkg::sample_t   audio_ls,
	input  sys_pkg::sample_t   audio_rs,
	input  logic               audio_s,
	input  logic [1:0]         audio_mix,
	output sys_pkg::sample_t   audio_l,
	output sys_pkg::sample_t   audio_r,

	// LEDs
	input  logic               led_user,
	input  logic [1:0]         led_power,
	input  logic [1:0]         led_disk,
	output logic               led_p,
	output logic               led_d,
	output logic               led_u,
	output sys_pkg::led_mask_t led,

	// Syncs
	input  logic               hs_in,
	input  logic               vs_in,
	output logic               hs_out,
	output logic               vs_out,

	// Video timing
	output sys_pkg::timing_t   width,
	output sys_pkg::timing_t   hfp,
	output sys_pkg::timing_t   hs_len,
	output sys_pkg::timing_t   hbp,
	output sys_pkg::timing_t   height,
	output sys_pkg::timing_t   vfp,
	output sys_pkg::timing_t   vs_len,
	output sys_pkg::timing_t   vbp
);
	import sys_pkg::*;

	vol_t      vol_att;
	led_mask_t led_overtake;
	led_mask_t led_state;

	host_cmd i_host_cmd (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.io_din       (io_din),
		.io_clk       (io_clk),
		.io_uio       (io_uio),
		.io_ack       (io_ack),
		.width        (width),
		.hfp          (hfp),
		.hs_len       (hs_len),
		.hbp          (hbp),
		.height       (height),
		.vfp          (vfp),
		.vs_len       (vs_len),
		.vbp          (vbp),
		.led_overtake (led_overtake),
		.led_state    (led_state),
		.vol_att      (vol_att)
	);

	audio_mix i_audio_mix (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.audio_ls     (audio_ls),
		.audio_rs     (audio_rs),
		.audio_s      (audio_s),
		.audio_mix    (audio_mix),
		.vol_att      (vol_att),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	panel_leds i_panel_leds (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.led_user     (led_user),
		.led_power    (led_power),
		.led_disk     (led_disk),
		.led_overtake (led_overtake),
		.led_state    (led_state),
		.led_p        (led_p),
		.led_d        (led_d),
		.led_u        (led_u),
		.led          (led)
	);

	sync_fix sync_h (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_in      (hs_in),
		.sync_out     (hs_out)
	);

	sync_fix sync_v (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_in      (vs_in),
		.sync_out     (vs_out)
	);

endmodule

// ==== tb_sys_core.sv ====
// Drives sys_core through host frames, audio mix, LEDs and sync polarity
// Outputs are sampled on the falling clock edge, inputs change on the rising edge

`timescale 1ns/10ps

module tb_sys_core;
	import sys_pkg::*;

	logic        FPGA_CLK2_50;
	logic        resetd;
	word_t       io_din;
	logic        io_clk;
	logic        io_uio;
	logic        io_ack;
	sample_t     audio_ls;
	sample_t     audio_rs;
	logic        audio_s;
	logic [1:0]  audio_mix;
	sample_t     audio_l;
	sample_t     audio_r;
	logic        led_user;
	logic [1:0]  led_power;
	logic [1:0]  led_disk;
	logic        led_p;
	logic        led_d;
	logic        led_u;
	led_mask_t   led;
	logic        hs_in;
	logic        vs_in;
	logic        hs_out;
	logic        vs_out;
	timing_t     width;
	timing_t     hfp;
	timing_t     hs_len;
	timing_t     hbp;
	timing_t     height;
	timing_t     vfp;
	timing_t     vs_len;
	timing_t     vbp;

	logic [31:0] lfsr;
	timing_t     exp_tim [8];

	sys_core i_sys_core (.*);

	initial begin
		FPGA_CLK2_50 = 1'b0;
		forever begin
			#50 FPGA_CLK2_50 = ~FPGA_CLK2_50;
		end
	end

	// ========================================
	// Random numbers and reference models
	// ========================================

	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			lfsr_next = (s >> 1) ^ 32'h8020_0003;
		end else begin
			lfsr_next = s >> 1;
		end
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Shifts one bit at a time with sign fill only for signed samples
	function automatic sample_t shift_down(input sample_t x, input int n, input logic s);
		sample_t r;
		int i;
		r = x;
		for (i = 0; i < n; i++) begin
			r = {s & r[15], r[15:1]};
		end
		shift_down = r;
	endfunction

	function automatic sample_t audio_ref(input sample_t own, input sample_t other,
			input logic [1:0] mix, input logic s, input vol_t vol);
		sample_t m;
		case (mix)
			2'd0: m = own;
			2'd1: m = own - shift_down(own, 3, s) + shift_down(other, 3, s);
			2'd2: m = own - shift_down(own, 2, s) + shift_down(other, 2, s);
			default: m = shift_down(own, 1, s) + shift_down(other, 1, s);
		endcase
		if (vol[4]) begin
			audio_ref = '0;
		end else begin
			audio_ref = shift_down(m, {28'd0, vol[3:0]}, s);
		end
	endfunction

	// Packed as {led, led_p, led_d, led_u}
	function automatic logic [10:0] led_ref(input logic user, input logic [1:0] power,
			input logic [1:0] disk, input led_mask_t ovr, input led_mask_t st);
		logic      p;
		logic      d;
		logic      u;
		led_mask_t bank;
		int        i;
		p = power[1] && !power[0];
		d = !disk[0];
		u = !user;
		bank = '0;
		bank[0] = !u;
		bank[2] = !d;
		bank[4] = !p;
		for (i = 0; i < 8; i++) begin
			if (ovr[i]) begin
				bank[i] = st[i];
			end
		end
		led_ref = {bank, p, d, u};
	endfunction

	// Shorter phase comes out high
	function automatic logic sync_ref(input logic in, input int hi_len, input int lo_len);
		sync_ref = (hi_len > lo_len) ? !in : in;
	endfunction

	// ========================================
	// Checks and host access
	// ========================================

	task automatic stop_on_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: time %0t ns, %s got %h expected %h", $time, name, got, exp);
			stop_on_failure("value mismatch");
		end
	endtask

	task automatic check_timing();
		check("width", {20'd0, width}, {20'd0, exp_tim[0]});
		check("hfp", {20'd0, hfp}, {20'd0, exp_tim[1]});
		check("hs_len", {20'd0, hs_len}, {20'd0, exp_tim[2]});
		check("hbp", {20'd0, hbp}, {20'd0, exp_tim[3]});
		check("height", {20'd0, height}, {20'd0, exp_tim[4]});
		check("vfp", {20'd0, vfp}, {20'd0, exp_tim[5]});
		check("vs_len", {20'd0, vs_len}, {20'd0, exp_tim[6]});
		check("vbp", {20'd0, vbp}, {20'd0, exp_tim[7]});
	endtask

	task automatic wait_ack(input logic level);
		int t;
		t = 0;
		@(negedge FPGA_CLK2_50);
		while (io_ack !== level) begin
			if (t >= 20) begin
				stop_on_failure("io_ack did not follow io_clk in time");
			end
			t++;
			@(negedge FPGA_CLK2_50);
		end
	endtask

	task automatic host_word(input word_t w);
		@(posedge FPGA_CLK2_50);
		io_din <= w;
		io_clk <= 1'b1;
		wait_ack(1'b1);
		@(posedge FPGA_CLK2_50);
		io_clk <= 1'b0;
		wait_ack(1'b0);
	endtask

	// io_uio passes two sync stages before the decoder sees it
	task automatic frame_edge(input logic level);
		@(posedge FPGA_CLK2_50);
		io_uio <= level;
		repeat (3) @(posedge FPGA_CLK2_50);
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		logic [31:0] v;
		logic [31:0] w;
		logic [10:0] le;
		vol_t        vol;
		int          i;
		int          k;
		int          m;
		int          c;

		lfsr = 32'h367b;
		resetd = 1'b1;
		io_din = '0;
		io_clk = 1'b0;
		io_uio = 1'b0;
		audio_ls = '0;
		audio_rs = '0;
		audio_s = 1'b0;
		audio_mix = 2'd0;
		led_user = 1'b0;
		led_power = 2'd0;
		led_disk = 2'd0;
		hs_in = 1'b0;
		vs_in = 1'b0;
		exp_tim = '{WIDTH_DEF, HFP_DEF, HS_DEF, HBP_DEF, HEIGHT_DEF, VFP_DEF, VS_DEF, VBP_DEF};
		repeat (2) @(posedge FPGA_CLK2_50);
		resetd <= 1'b0;

		// Timing defaults, then a full load with two PLL words after it
		@(negedge FPGA_CLK2_50);
		check("io_ack", {31'd0, io_ack}, 32'd0);
		check_timing();
		frame_edge(1'b1);
		host_word({8'h00, CMD_TIMING});
		for (i = 0; i < 10; i++) begin
			draw(16, w);
			host_word(w[15:0]);
			if (i < 8) begin
				exp_tim[i] = w[11:0];
			end
		end
		frame_edge(1'b0);
		check_timing();

		// Unknown command leaves everything alone
		frame_edge(1'b1);
		host_word(16'h0033);
		for (i = 0; i < 3; i++) begin
			draw(16, w);
			host_word(w[15:0]);
		end
		frame_edge(1'b0);
		check_timing();
		le = led_ref(led_user, led_power, led_disk, 8'h00, 8'h00);
		check("led_p", {31'd0, led_p}, {31'd0, le[2]});
		check("led", {24'd0, led}, {24'd0, le[10:3]});

		// Fresh frame is decoded from its first word
		frame_edge(1'b1);
		host_word({8'h00, CMD_TIMING});
		for (i = 0; i < 2; i++) begin
			draw(16, w);
			host_word(w[15:0]);
			exp_tim[i] = w[11:0];
		end
		frame_edge(1'b0);
		check_timing();

		// Audio with the last volume setting a mute
		for (k = 0; k < 6; k++) begin
			draw(4, w);
			vol = {(k == 5), w[3:0]};
			frame_edge(1'b1);
			host_word({8'h00, CMD_VOLUME});
			host_word({11'd0, vol});
			frame_edge(1'b0);
			for (m = 0; m < 8; m++) begin
				draw(16, v);
				draw(16, w);
				@(posedge FPGA_CLK2_50);
				audio_ls <= v[15:0];
				audio_rs <= w[15:0];
				audio_mix <= m[2:1];
				audio_s <= m[0];
				repeat (2) @(posedge FPGA_CLK2_50);
				@(negedge FPGA_CLK2_50);
				check("audio_l", {16'd0, audio_l},
					{16'd0, audio_ref(v[15:0], w[15:0], m[2:1], m[0], vol)});
				check("audio_r", {16'd0, audio_r},
					{16'd0, audio_ref(w[15:0], v[15:0], m[2:1], m[0], vol)});
			end
		end

		// Panel LEDs with a random override each round
		for (k = 0; k < 8; k++) begin
			draw(16, w);
			frame_edge(1'b1);
			host_word({8'h00, CMD_LED});
			host_word(w[15:0]);
			frame_edge(1'b0);
			for (m = 0; m < 4; m++) begin
				draw(5, v);
				@(posedge FPGA_CLK2_50);
				led_user <= v[0];
				led_power <= v[2:1];
				led_disk <= v[4:3];
				@(posedge FPGA_CLK2_50);
				@(negedge FPGA_CLK2_50);
				le = led_ref(v[0], v[2:1], v[4:3], w[15:8], w[7:0]);
				check("led_u", {31'd0, led_u}, {31'd0, le[0]});
				check("led_d", {31'd0, led_d}, {31'd0, le[1]});
				check("led_p", {31'd0, led_p}, {31'd0, le[2]});
				check("led", {24'd0, led}, {24'd0, le[10:3]});
			end
		end

		// Sync stimulus with hs high 4 of 40 cycles and vs low 6 of 60
		for (c = 0; c < 480; c++) begin
			@(posedge FPGA_CLK2_50);
			hs_in <= (c % 40) < 4;
			vs_in <= (c % 60) >= 6;
			@(negedge FPGA_CLK2_50);
			if (c >= 180) begin
				if ((c % 40) == 2 || (c % 40) == 22) begin
					check("hs_out", {31'd0, hs_out}, {31'd0, sync_ref(hs_in, 4, 36)});
				end
				if ((c % 60) == 3 || (c % 60) == 33) begin
					check("vs_out", {31'd0, vs_out}, {31'd0, sync_ref(vs_in, 54, 6)});
				end
			end
		end

		$display("Test passed");
		$finish;
	end

endmodule

// ==== filelist.f ====
sys_pkg.sv
host_cmd.sv
audio_mix.sv
panel_leds.sv
sync_fix.sv
sys_core.sv
tb_sys_core.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_sys_core

$(SIM): filelist.f sys_pkg.sv host_cmd.sv audio_mix.sv panel_leds.sv sync_fix.sv sys_core.sv tb_sys_core.sv
	verilator --binary --timing -Wno-fatal --top-module tb_sys_core -f filelist.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: run clean
